// ==== rtl/udp_tx_cfg.svh ====
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

////////////////////////////////////////////////////////////
// Fragmentation limits
////////////////////////////////////////////////////////////

// Largest UDP payload carried by one IPv4 fragment
`define UDP_TX_MAX_PAYLOAD 1472
// 1472 bytes expressed in 8-byte offset units
`define UDP_TX_FRAG_OFFSET_STEP 184

////////////////////////////////////////////////////////////
// Protocol constants and field widths in bytes
////////////////////////////////////////////////////////////

`define UDP_TX_PROTOCOL_UDP 8'h11
`define UDP_TX_UDP_HEADER_BYTES 8
`define UDP_TX_MAC_BYTES 6
`define UDP_TX_IP_BYTES 4
`define UDP_TX_PORT_BYTES 2

`endif

// ==== rtl/udp_tx_pkg.sv ====
package udp_tx_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] byte_count_t;
    typedef logic [15:0] buffer_addr_t;

    // Bit 13 more fragments, bits 12:0 offset in 8-byte units
    typedef logic [15:0] ipv4_flags_t;

    typedef enum logic [2:0] {
        FIELD_MAC,
        FIELD_DEST_IP,
        FIELD_SIZE,
        FIELD_SRC_PORT,
        FIELD_DST_PORT,
        FIELD_PAYLOAD
    } field_kind_t;

    // One command byte tagged with its field
    typedef struct packed {
        logic        valid;
        field_kind_t kind;
        logic        last;
        logic [7:0]  data;
    } field_byte_t;

    typedef struct packed {
        mac_addr_t   mac_destination;
        ipv4_addr_t  ipv4_destination;
        udp_port_t   udp_source;
        udp_port_t   udp_destination;
        byte_count_t udp_total_payload_size;
    } udp_header_t;

    typedef struct packed {
        logic         valid;
        buffer_addr_t address;
        logic [7:0]   data;
    } buffer_write_t;

    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
    } checksum_byte_t;

    typedef struct packed {
        ipv4_flags_t ipv4_flags;
        byte_count_t udp_fragment_size;
        logic [15:0] ipv4_identification;
    } fragment_t;

endpackage

// ==== rtl/udp_command_parser.sv ====
`timescale 1ns/1ps
`include "udp_tx_cfg.svh"

module udp_command_parser (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [8:0]                 data,
    input  logic                       data_enable,
    input  logic                       seq_ready,
    input  logic                       sched_busy,
    output logic                       data_ready,
    output udp_tx_pkg::udp_header_t    header,
    output udp_tx_pkg::field_byte_t    field_out,
    output udp_tx_pkg::buffer_write_t  buffer_write,
    output logic                       frame_loaded
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MAC,
        S_DEST_IP,
        S_SIZE,
        S_SRC_PORT,
        S_DST_PORT,
        S_PAYLOAD,
        S_WAIT_SCHED
    } state_t;

    state_t                   state;
    state_t                   next_field_state;
    udp_tx_pkg::byte_count_t  byte_count;
    udp_tx_pkg::byte_count_t  field_length;
    udp_tx_pkg::field_kind_t  field_kind;
    logic                     accept;
    logic                     field_done;
    logic [7:0]               data_byte;

    // No new bytes while the scheduler owns the frame
    assign data_ready = seq_ready && (state != S_WAIT_SCHED);
    assign accept     = data_enable && data_ready;
    assign data_byte  = data[7:0];
    assign field_done = (byte_count == field_length - 1'b1);

    ////////////////////////////////////////////////////////////
    // Field length, tag and successor per state
    ////////////////////////////////////////////////////////////
    always_comb begin
        field_length     = 16'(`UDP_TX_MAC_BYTES);
        field_kind       = udp_tx_pkg::FIELD_MAC;
        next_field_state = S_DEST_IP;
        case (state)
            S_DEST_IP: begin
                field_length     = 16'(`UDP_TX_IP_BYTES);
                field_kind       = udp_tx_pkg::FIELD_DEST_IP;
                next_field_state = S_SIZE;
            end
            S_SIZE: begin
                field_length     = 16'($bits(udp_tx_pkg::byte_count_t) / 8);
                field_kind       = udp_tx_pkg::FIELD_SIZE;
                next_field_state = S_SRC_PORT;
            end
            S_SRC_PORT: begin
                field_length     = 16'(`UDP_TX_PORT_BYTES);
                field_kind       = udp_tx_pkg::FIELD_SRC_PORT;
                next_field_state = S_DST_PORT;
            end
            S_DST_PORT: begin
                field_length     = 16'(`UDP_TX_PORT_BYTES);
                field_kind       = udp_tx_pkg::FIELD_DST_PORT;
                next_field_state = S_PAYLOAD;
            end
            S_PAYLOAD: begin
                field_length     = header.udp_total_payload_size;
                field_kind       = udp_tx_pkg::FIELD_PAYLOAD;
                next_field_state = S_WAIT_SCHED;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= S_IDLE;
            byte_count   <= '0;
            header       <= '0;
            field_out    <= '0;
            buffer_write <= '0;
            frame_loaded <= 1'b0;
        end else begin
            field_out.valid    <= 1'b0;
            buffer_write.valid <= 1'b0;
            frame_loaded       <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Unmarked bytes are dropped here
                    if (accept && data[8]) begin
                        header.mac_destination <= {header.mac_destination[39:0], data_byte};
                        field_out  <= '{valid: 1'b1, kind: udp_tx_pkg::FIELD_MAC,
                                        last: 1'b0, data: data_byte};
                        byte_count <= 16'd1;
                        state      <= S_MAC;
                    end
                end
                S_WAIT_SCHED: begin
                    if (!sched_busy) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    if (accept) begin
                        field_out <= '{valid: 1'b1, kind: field_kind,
                                       last: field_done, data: data_byte};
                        case (state)
                            S_MAC: header.mac_destination <=
                                {header.mac_destination[39:0], data_byte};
                            S_DEST_IP: header.ipv4_destination <=
                                {header.ipv4_destination[23:0], data_byte};
                            S_SIZE: header.udp_total_payload_size <=
                                {header.udp_total_payload_size[7:0], data_byte};
                            S_SRC_PORT: header.udp_source <=
                                {header.udp_source[7:0], data_byte};
                            S_DST_PORT: header.udp_destination <=
                                {header.udp_destination[7:0], data_byte};
                            default: buffer_write <= '{valid: 1'b1, address: byte_count,
                                                       data: data_byte};
                        endcase
                        if (field_done) begin
                            byte_count   <= '0;
                            state        <= next_field_state;
                            frame_loaded <= (state == S_PAYLOAD);
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/udp_checksum_sequencer.sv ====
`timescale 1ns/1ps
`include "udp_tx_cfg.svh"

module udp_checksum_sequencer (
    input  logic                        clock,
    input  logic                        reset_n,
    input  udp_tx_pkg::field_byte_t     field_in,
    input  udp_tx_pkg::ipv4_addr_t      ipv4_source,
    output logic                        seq_ready,
    output udp_tx_pkg::checksum_byte_t  checksum
);

    typedef enum logic [1:0] {
        S_PASS,
        S_WAIT_FIRST,
        S_INSERT,
        S_EMIT_HELD
    } state_t;

    state_t                   state;
    udp_tx_pkg::field_byte_t  held;
    udp_tx_pkg::field_byte_t  current;
    udp_tx_pkg::byte_count_t  payload_size;
    udp_tx_pkg::byte_count_t  udp_length;
    logic [31:0]              insert_shift;
    logic [31:0]              insert_load;
    logic [1:0]               insert_count;
    logic                     opens_gap;

    assign udp_length = payload_size + 16'(`UDP_TX_UDP_HEADER_BYTES);
    assign current    = (state == S_EMIT_HELD) ? held : field_in;

    // Field ends that are followed by pseudo-header bytes
    assign opens_gap = field_in.valid && field_in.last &&
                       (field_in.kind inside {udp_tx_pkg::FIELD_MAC, udp_tx_pkg::FIELD_DEST_IP,
                                              udp_tx_pkg::FIELD_SIZE, udp_tx_pkg::FIELD_DST_PORT});

    // Bytes inserted ahead of the first byte of each field
    always_comb begin
        case (field_in.kind)
            udp_tx_pkg::FIELD_DEST_IP: insert_load = ipv4_source;
            udp_tx_pkg::FIELD_SIZE:    insert_load = {8'h00, 8'(`UDP_TX_PROTOCOL_UDP), 16'h0000};
            default:                   insert_load = {udp_length, 16'h0000};
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= S_PASS;
            seq_ready    <= 1'b1;
            held         <= '0;
            payload_size <= '0;
            insert_shift <= '0;
            insert_count <= '0;
            checksum     <= '0;
        end else begin
            checksum.valid <= 1'b0;
            checksum.last  <= 1'b0;

            ////////////////////////////////////////////////////////////
            // Consume a tagged byte, either direct or held
            ////////////////////////////////////////////////////////////
            if ((state == S_PASS || state == S_EMIT_HELD) && current.valid) begin
                if (current.kind == udp_tx_pkg::FIELD_SIZE) begin
                    payload_size <= {payload_size[7:0], current.data};
                end
                checksum.valid <= !(current.kind inside {udp_tx_pkg::FIELD_MAC,
                                                         udp_tx_pkg::FIELD_SIZE});
                checksum.last  <= (current.kind == udp_tx_pkg::FIELD_PAYLOAD) && current.last;
                checksum.data  <= current.data;
            end

            case (state)
                S_PASS: begin
                    if (opens_gap) begin
                        seq_ready <= 1'b0;
                        state     <= S_WAIT_FIRST;
                    end
                end
                S_WAIT_FIRST: begin
                    if (field_in.valid) begin
                        held         <= field_in;
                        insert_shift <= insert_load;
                        insert_count <= (field_in.kind == udp_tx_pkg::FIELD_DEST_IP) ?
                                        2'(`UDP_TX_IP_BYTES - 1) : 2'd1;
                        state        <= S_INSERT;
                    end else begin
                        // Single-cycle ready windows, at most one byte in flight
                        seq_ready <= !seq_ready;
                    end
                end
                S_INSERT: begin
                    checksum     <= '{valid: 1'b1, last: 1'b0, data: insert_shift[31:24]};
                    insert_shift <= {insert_shift[23:0], 8'h00};
                    insert_count <= insert_count - 1'b1;
                    if (insert_count == 2'd0) begin
                        state <= S_EMIT_HELD;
                    end
                end
                default: begin
                    seq_ready <= 1'b1;
                    state     <= S_PASS;
                end
            endcase
        end
    end

endmodule

// ==== rtl/udp_fragment_scheduler.sv ====
`timescale 1ns/1ps
`include "udp_tx_cfg.svh"

module udp_fragment_scheduler (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     enable,
    input  logic                     frame_loaded,
    input  udp_tx_pkg::byte_count_t  payload_size,
    output logic                     sched_busy,
    output logic                     transmit_valid,
    output udp_tx_pkg::fragment_t    fragment
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SETUP,
        S_OFFER,
        S_WAIT_BUSY,
        S_WAIT_DONE
    } state_t;

    state_t                   state;
    udp_tx_pkg::byte_count_t  bytes_left;

    // Covers the frame_loaded cycle so the parser never sees a gap
    assign sched_busy = (state != S_IDLE) || frame_loaded;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= S_IDLE;
            bytes_left     <= '0;
            fragment       <= '0;
            transmit_valid <= 1'b0;
        end else begin
            transmit_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (frame_loaded) begin
                        bytes_left          <= payload_size;
                        fragment.ipv4_flags <= '0;
                        state               <= S_SETUP;
                    end
                end

                ////////////////////////////////////////////////////////////
                // Size and more-fragments bit of the next fragment
                ////////////////////////////////////////////////////////////
                S_SETUP: begin
                    if (bytes_left > 16'(`UDP_TX_MAX_PAYLOAD)) begin
                        fragment.udp_fragment_size <= 16'(`UDP_TX_MAX_PAYLOAD);
                        fragment.ipv4_flags[13]    <= 1'b1;
                        bytes_left                 <= bytes_left - 16'(`UDP_TX_MAX_PAYLOAD);
                    end else begin
                        fragment.udp_fragment_size <= bytes_left;
                        fragment.ipv4_flags[13]    <= 1'b0;
                        bytes_left                 <= '0;
                    end
                    state <= S_OFFER;
                end
                S_OFFER: begin
                    if (enable) begin
                        transmit_valid <= 1'b1;
                        state          <= S_WAIT_BUSY;
                    end
                end
                // Transmitter drops enable while sending
                S_WAIT_BUSY: begin
                    if (!enable) begin
                        state <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (enable) begin
                        if (bytes_left == '0) begin
                            fragment.ipv4_identification <= fragment.ipv4_identification + 1'b1;
                            state                        <= S_IDLE;
                        end else begin
                            fragment.ipv4_flags[12:0] <= fragment.ipv4_flags[12:0] +
                                                         13'(`UDP_TX_FRAG_OFFSET_STEP);
                            state                     <= S_SETUP;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/udp_transmit_handler.sv ====
`timescale 1ns/1ps

module udp_transmit_handler (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        enable,
    input  logic [8:0]                  data,
    input  logic                        data_enable,
    input  udp_tx_pkg::ipv4_addr_t      ipv4_source,
    output logic                        data_ready,
    output udp_tx_pkg::udp_header_t     header,
    output udp_tx_pkg::buffer_write_t   buffer_write,
    output udp_tx_pkg::checksum_byte_t  checksum,
    output udp_tx_pkg::fragment_t       fragment,
    output logic                        transmit_valid
);

    udp_tx_pkg::field_byte_t  field_byte;
    logic                     seq_ready;
    logic                     sched_busy;
    logic                     frame_loaded;

    ////////////////////////////////////////////////////////////
    // Parser, checksum sequencer, fragment scheduler
    ////////////////////////////////////////////////////////////

    udp_command_parser u_parser (
        .clock        (clock),
        .reset_n      (reset_n),
        .data         (data),
        .data_enable  (data_enable),
        .seq_ready    (seq_ready),
        .sched_busy   (sched_busy),
        .data_ready   (data_ready),
        .header       (header),
        .field_out    (field_byte),
        .buffer_write (buffer_write),
        .frame_loaded (frame_loaded)
    );

    udp_checksum_sequencer u_sequencer (
        .clock       (clock),
        .reset_n     (reset_n),
        .field_in    (field_byte),
        .ipv4_source (ipv4_source),
        .seq_ready   (seq_ready),
        .checksum    (checksum)
    );

    // Size field is complete by the time frame_loaded pulses
    udp_fragment_scheduler u_scheduler (
        .clock          (clock),
        .reset_n        (reset_n),
        .enable         (enable),
        .frame_loaded   (frame_loaded),
        .payload_size   (header.udp_total_payload_size),
        .sched_busy     (sched_busy),
        .transmit_valid (transmit_valid),
        .fragment       (fragment)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Reset low for eight cycles, released just after an edge
    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset_n = 1'b1;
    end

endmodule

// ==== test/udp_transmit_handler_assertions.sv ====
`timescale 1ns/1ps

module udp_transmit_handler_assertions (
    input logic                        clock,
    input logic                        reset_n,
    input logic                        transmit_valid,
    input udp_tx_pkg::checksum_byte_t  checksum,
    input logic                        data_ready,
    input logic                        frame_loaded
);

    int failure_count = 0;

    // Offer to the transmitter is a single-cycle pulse
    transmit_pulse: assert property (
        @(posedge clock) disable iff (!reset_n)
        transmit_valid |=> !transmit_valid
    ) else begin
        failure_count++;
        $error("transmit_valid stayed high for more than one cycle");
    end

    last_with_valid: assert property (
        @(posedge clock) disable iff (!reset_n)
        checksum.last |-> checksum.valid
    ) else begin
        failure_count++;
        $error("checksum last seen without checksum valid");
    end

    // Parser must hold off input once the frame is handed over
    ready_after_load: assert property (
        @(posedge clock) disable iff (!reset_n)
        frame_loaded |=> !data_ready
    ) else begin
        failure_count++;
        $error("data_ready high in the cycle after frame_loaded");
    end

endmodule

// ==== test/udp_transmit_handler_tb.sv ====
`timescale 1ns/1ps
`include "udp_tx_cfg.svh"

module udp_transmit_handler_tb;

    // About 3300 input bytes over all tests plus a few handshakes, so ample margin
    localparam int CYCLE_LIMIT    = 20000;
    localparam int TX_BUSY_CYCLES = 4;

    logic                        clock;
    logic                        reset_n;
    logic                        enable;
    logic [8:0]                  data;
    logic                        data_enable;
    udp_tx_pkg::ipv4_addr_t      ipv4_source;
    logic                        data_ready;
    udp_tx_pkg::udp_header_t     header;
    udp_tx_pkg::buffer_write_t   buffer_write;
    udp_tx_pkg::checksum_byte_t  checksum;
    udp_tx_pkg::fragment_t       fragment;
    logic                        transmit_valid;

    logic [31:0]            rng_state;
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     cycles = 0;
    logic [15:0]            expected_id;

    logic [8:0]             checksum_seen[$];
    logic [8:0]             checksum_expected[$];
    logic [23:0]            writes_seen[$];
    udp_tx_pkg::fragment_t  fragments_seen[$];
    logic [7:0]             payload[$];

    tb_clock_gen u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    udp_transmit_handler u_dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .enable         (enable),
        .data           (data),
        .data_enable    (data_enable),
        .ipv4_source    (ipv4_source),
        .data_ready     (data_ready),
        .header         (header),
        .buffer_write   (buffer_write),
        .checksum       (checksum),
        .fragment       (fragment),
        .transmit_valid (transmit_valid)
    );

    bind udp_transmit_handler udp_transmit_handler_assertions u_assertions (
        .clock          (clock),
        .reset_n        (reset_n),
        .transmit_valid (transmit_valid),
        .checksum       (checksum),
        .data_ready     (data_ready),
        .frame_loaded   (frame_loaded)
    );

    ////////////////////////////////////////////////////////////
    // Monitors and timeout
    ////////////////////////////////////////////////////////////

    // Sampled mid-cycle, away from the registered updates
    always @(negedge clock) begin
        if (reset_n) begin
            if (checksum.valid) begin
                checksum_seen.push_back({checksum.last, checksum.data});
            end
            if (buffer_write.valid) begin
                writes_seen.push_back({buffer_write.address, buffer_write.data});
            end
            if (transmit_valid) begin
                fragments_seen.push_back(fragment);
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pick_gap(input int max_gap);
        if (max_gap == 0) begin
            return 0;
        end
        rng_state = xorshift(rng_state);
        return int'(rng_state % 32'(max_gap + 1));
    endfunction

    // Transmitter drops enable for a while after each offer
    task automatic model_transmitter();
        forever begin
            @(negedge clock);
            if (transmit_valid) begin
                @(posedge clock);
                #1;
                enable = 1'b0;
                repeat (TX_BUSY_CYCLES) @(posedge clock);
                #1;
                enable = 1'b1;
            end
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic send_byte(input logic [8:0] value, input int gap);
        logic taken;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        data        = value;
        data_enable = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = data_ready;
            @(posedge clock);
            #1;
        end
        data_enable = 1'b0;
    endtask

    task automatic wait_frame_done(input int fragment_count);
        while (fragments_seen.size() < fragment_count) begin
            @(negedge clock);
        end
        @(negedge clock);
        while (!data_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string test_name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string test_name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One command through the whole pipeline
    ////////////////////////////////////////////////////////////

    task automatic run_frame(
        input string                   test_name,
        input udp_tx_pkg::mac_addr_t   mac,
        input udp_tx_pkg::ipv4_addr_t  ip,
        input udp_tx_pkg::udp_port_t   source_port,
        input udp_tx_pkg::udp_port_t   dest_port,
        input int                      size,
        input int                      max_gap
    );
        logic [127:0]           head;
        logic [143:0]           pseudo;
        logic [15:0]            udp_length;
        udp_tx_pkg::fragment_t  exp_frag;
        int                     remaining;
        int                     offset;
        int                     fragment_count;
        checksum_seen.delete();
        checksum_expected.delete();
        writes_seen.delete();
        fragments_seen.delete();
        payload.delete();
        for (int i = 0; i < size; i++) begin
            rng_state = xorshift(rng_state);
            payload.push_back(rng_state[7:0]);
        end

        // Pseudo-header and UDP header order, then payload
        udp_length = 16'(size + `UDP_TX_UDP_HEADER_BYTES);
        pseudo = {ipv4_source, ip, 8'h00, `UDP_TX_PROTOCOL_UDP, udp_length,
                  source_port, dest_port, udp_length};
        for (int i = 0; i < 18; i++) begin
            checksum_expected.push_back({1'b0, pseudo[143 - 8 * i -: 8]});
        end
        for (int i = 0; i < size; i++) begin
            checksum_expected.push_back({i == size - 1, payload[i]});
        end

        head = {mac, ip, 16'(size), source_port, dest_port};
        for (int i = 0; i < 16; i++) begin
            send_byte({i == 0, head[127 - 8 * i -: 8]}, pick_gap(max_gap));
        end
        for (int i = 0; i < size; i++) begin
            send_byte({1'b0, payload[i]}, pick_gap(max_gap));
        end
        fragment_count = (size + `UDP_TX_MAX_PAYLOAD - 1) / `UDP_TX_MAX_PAYLOAD;
        wait_frame_done(fragment_count);

        check_value(test_name, "MAC destination", 64'(mac), 64'(header.mac_destination));
        check_value(test_name, "IPv4 destination", 64'(ip), 64'(header.ipv4_destination));
        check_value(test_name, "UDP source", 64'(source_port), 64'(header.udp_source));
        check_value(test_name, "UDP destination", 64'(dest_port),
                    64'(header.udp_destination));
        check_value(test_name, "payload size", 64'(size),
                    64'(header.udp_total_payload_size));

        check_count(test_name, "checksum bytes", checksum_expected.size(),
                    checksum_seen.size());
        for (int i = 0; i < checksum_expected.size() && i < checksum_seen.size(); i++) begin
            check_value(test_name, $sformatf("checksum {last,data} %0d", i),
                        64'(checksum_expected[i]), 64'(checksum_seen[i]));
        end

        check_count(test_name, "buffer writes", size, writes_seen.size());
        for (int i = 0; i < size && i < writes_seen.size(); i++) begin
            check_value(test_name, $sformatf("buffer write %0d", i),
                        64'({16'(i), payload[i]}), 64'(writes_seen[i]));
        end

        check_count(test_name, "fragments", fragment_count, fragments_seen.size());
        remaining = size;
        offset    = 0;
        for (int i = 0; i < fragment_count && i < fragments_seen.size(); i++) begin
            exp_frag.udp_fragment_size   = 16'((remaining > `UDP_TX_MAX_PAYLOAD) ?
                                               `UDP_TX_MAX_PAYLOAD : remaining);
            exp_frag.ipv4_flags          = {2'b00, remaining > `UDP_TX_MAX_PAYLOAD,
                                            13'(offset)};
            exp_frag.ipv4_identification = expected_id;
            check_value(test_name, $sformatf("fragment %0d", i),
                        64'(exp_frag), 64'(fragments_seen[i]));
            remaining = remaining - int'(exp_frag.udp_fragment_size);
            offset    = offset + `UDP_TX_FRAG_OFFSET_STEP;
        end
        expected_id = expected_id + 16'd1;
        check_value(test_name, "identification after frame", 64'(expected_id),
                    64'(fragment.ipv4_identification));
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int errors_before;
        errors_before = errors;
        check_value("reset_state", "data_ready", 64'(1), 64'(data_ready));
        check_value("reset_state", "transmit_valid", 64'(0), 64'(transmit_valid));
        check_value("reset_state", "checksum", 64'(0), 64'(checksum));
        check_value("reset_state", "buffer write valid", 64'(0), 64'(buffer_write.valid));
        check_value("reset_state", "header high", 64'(0), 64'(header[127:64]));
        check_value("reset_state", "header low", 64'(0), 64'(header[63:0]));
        check_value("reset_state", "fragment", 64'(0), 64'(fragment));
        report_test("reset_state", errors_before);
    endtask

    // Stray unmarked bytes come first and must be dropped
    task automatic test_single_frame();
        int errors_before;
        errors_before = errors;
        send_byte({1'b0, 8'h5a}, 0);
        send_byte({1'b0, 8'h02}, 1);
        send_byte({1'b0, 8'hff}, 0);
        run_frame("single_frame", 48'h02_00_5e_10_20_30, 32'h0a00_0001,
                  16'h1234, 16'h0050, 100, 0);
        report_test("single_frame", errors_before);
    endtask

    task automatic test_fragmentation();
        int errors_before;
        errors_before = errors;
        run_frame("fragmentation", 48'hac_de_48_00_11_22, 32'hc0a8_0164,
                  16'hc350, 16'h1f90, 3000, 0);
        report_test("fragmentation", errors_before);
    endtask

    task automatic test_gapped_input();
        int errors_before;
        errors_before = errors;
        run_frame("gapped_input", 48'h00_1b_21_3c_4d_5e, 32'h0a01_02fe,
                  16'h0400, 16'h0035, 64, 3);
        report_test("gapped_input", errors_before);
    endtask

    initial begin
        enable      = 1'b1;
        data        = '0;
        data_enable = 1'b0;
        ipv4_source = 32'hc0a8_0a01;
        rng_state   = 32'h3acb;
        expected_id = '0;
        wait (reset_n);
        @(posedge clock);
        #1;
        test_reset_state();
        test_single_frame();
        test_fragmentation();
        test_gapped_input();

        errors = errors + u_dut.u_assertions.failure_count;
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        model_transmitter();
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/udp_tx_pkg.sv
rtl/udp_command_parser.sv
rtl/udp_checksum_sequencer.sv
rtl/udp_fragment_scheduler.sv
rtl/udp_transmit_handler.sv
test/tb_clock_gen.sv
test/udp_transmit_handler_assertions.sv
test/udp_transmit_handler_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module udp_transmit_handler_tb \
    -o udp_tx_sim \
    && output="$(./obj_dir/udp_tx_sim)" \
    || { echo "Build or simulation run failed"; exit 1; }

echo "$output"
grep -qx "TEST RESULT: PASS" <<< "$output" && exit 0 || exit 1
